/* Makefile */
TOP := ifu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check run.log for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee run.log
	grep -q "^Simulation passed$$" run.log

clean:
	rm -rf obj_dir run.log

/* build.f */
logic/ifu_pkg.sv
logic/ifu_imem_ctrl.sv
logic/ifu_parcel_align.sv
logic/ifu_instr_queue.sv
logic/ifu_top.sv
dv/ifu_sva.sv
dv/ifu_tb.sv

/* dv/ifu_sva.sv */
`timescale 1ns/1ns

module ifu_sva #(
    parameter int TXN_CNT_W = 3
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     req_i,
    input logic [ifu_pkg::XLEN-1:2] addr_i,
    input logic                     ack_i,
    input logic                     pc_new_req_i,
    input logic                     stop_fetch_i,
    input logic                     state_i,        // High in FETCH
    input logic [TXN_CNT_W-1:0]     pnd_cnt_i,
    input logic [TXN_CNT_W-1:0]     dsc_cnt_i
);
    int unsigned fail_cnt = 0;                      // Read by the testbench

    // --------------------------------------------------
    // Request side
    // --------------------------------------------------

    // Waiting request keeps its address unless redirected
    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_i && !ack_i |=> pc_new_req_i || $stable(addr_i))
        else begin
            fail_cnt++;
            $error("Request address changed while waiting for ack");
        end

    a_stop_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state_i && stop_fetch_i |=> !state_i)       // One cycle to IDLE
        else begin
            fail_cnt++;
            $error("FSM still in FETCH one cycle after stop");
        end

    // Drops never outnumber the requests in flight
    a_dsc_le_pnd: assert property (@(posedge clk) disable iff (!rst_n)
        dsc_cnt_i <= pnd_cnt_i)
        else begin
            fail_cnt++;
            $error("Discard count above pending count");
        end

endmodule

bind ifu_imem_ctrl ifu_sva #(
    .TXN_CNT_W    (TXN_CNT_W)
) i_ifu_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (imem_req_o.req),
    .addr_i       (imem_req_o.addr),
    .ack_i        (imem_ack_i),
    .pc_new_req_i (pc_new_req_i),
    .stop_fetch_i (stop_fetch_i),
    .state_i      (state),
    .pnd_cnt_i    (pnd_cnt),
    .dsc_cnt_i    (dsc_cnt)
);

/* dv/ifu_tb.sv */
`timescale 1ns/1ns

module ifu_tb;
    import ifu_pkg::*;

    localparam int MASK_AT       = 'h40;    // Fault mask, two words
    localparam int NTEST_AT      = 'h42;
    localparam int REC_AT        = 'h43;    // pc, mode, count
    localparam int EXP_AT        = 'h60;    // instr, flags pairs
    localparam int CYC_PER_INSTR = 200;
    localparam int CYC_PER_TEST  = 80;      // Reset, silence and stop windows

    logic            clk;
    logic            rst_n;
    logic            pc_new_req_i;
    logic [XLEN-1:0] pc_new_i;
    logic            stop_fetch_i;
    imem_req_t       imem_req_o;
    logic            imem_ack_i;
    imem_resp_t      imem_resp_i;
    idu_out_t        idu_o;
    logic            idu_rdy_i;

    logic [31:0]     tdata [0:255];
    logic [63:0]     err_mask;
    int              seed = 21527;
    int              cyc;
    int              pend_addr [$];         // Accepted word indices
    int              pend_due [$];          // Negedge cycle of the reply
    int              last_due;
    logic            stall = 1'b0;
    logic            slow = 1'b0;           // Long replies keep decoy words in flight
    logic            go = 1'b0;             // Decode stage may take instrs
    logic            loaded = 1'b0;
    int              consumed;
    int              exp_cnt = 0;
    int              exp_base;
    int              test_idx;
    int              errors;
    int              checks;
    int              watchdog_cycles;

    ifu_top #(
        .QUEUE_WORDS  (2),
        .TXN_CNT_W    (3)
    ) i_ifu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_new_req_i (pc_new_req_i),
        .pc_new_i     (pc_new_i),
        .stop_fetch_i (stop_fetch_i),
        .imem_req_o   (imem_req_o),
        .imem_ack_i   (imem_ack_i),
        .imem_resp_i  (imem_resp_i),
        .idu_o        (idu_o),
        .idu_rdy_i    (idu_rdy_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // Memory acceptance and stream monitor
    // --------------------------------------------------

    task automatic check_instr();
        logic [31:0] exp_instr;
        logic [31:0] exp_flags;
        exp_instr = tdata[exp_base + 2 * consumed];
        exp_flags = tdata[exp_base + 2 * consumed + 1];
        checks++;
        if (idu_o.instr !== exp_instr) begin
            errors++;
            $display("Mismatch test %0d item %0d: idu_o.instr = %h, expected %h",
                     test_idx, consumed, idu_o.instr, exp_instr);
        end
        if (idu_o.imem_err !== exp_flags[1]) begin
            errors++;
            $display("Mismatch test %0d item %0d: idu_o.imem_err = %h, expected %h",
                     test_idx, consumed, idu_o.imem_err, exp_flags[1]);
        end
        if (idu_o.err_rvi_hi !== exp_flags[0]) begin
            errors++;
            $display("Mismatch test %0d item %0d: idu_o.err_rvi_hi = %h, expected %h",
                     test_idx, consumed, idu_o.err_rvi_hi, exp_flags[0]);
        end
        consumed++;
    endtask

    always @(posedge clk) begin
        int d;
        int due;
        if (!rst_n) begin
            pend_addr.delete();
            pend_due.delete();
            last_due = 0;
            cyc      = 0;
            consumed = 0;
        end else begin
            cyc++;
            if (imem_req_o.req && imem_ack_i) begin
                d   = stall ? 1 + ($unsigned($random(seed)) % 3) : (slow ? 3 : 1);
                due = cyc + d - 1;                  // Same-cycle negedge = next edge
                if (due <= last_due) due = last_due + 1;   // One reply per cycle
                last_due = due;
                pend_addr.push_back(int'(imem_req_o.addr[7:2]));
                pend_due.push_back(due);
            end
            if (idu_o.valid && idu_rdy_i) check_instr();
        end
    end

    // --------------------------------------------------
    // Memory replies, ack and ready
    // --------------------------------------------------

    always @(negedge clk) begin
        logic [31:0] r;
        r          = $random(seed);
        imem_ack_i = stall ? r[0] : 1'b1;
        idu_rdy_i  = go && (consumed < exp_cnt) && (!stall || r[1]);
        if (pend_due.size() > 0 && cyc >= pend_due[0]) begin
            imem_resp_i.resp  = err_mask[pend_addr[0]] ? RESP_ERR : RESP_OK;
            imem_resp_i.rdata = tdata[pend_addr[0]];
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end else begin
            imem_resp_i.resp  = RESP_NONE;
            imem_resp_i.rdata = '0;
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    task automatic redirect(input logic [31:0] pc);
        pc_new_i     = pc;
        pc_new_req_i = 1'b1;                        // Single-cycle strobe
        @(negedge clk);
        pc_new_req_i = 1'b0;
    endtask

    task automatic run_test(input int t, input logic [31:0] pc, input logic [31:0] mode,
                            input int cnt);
        int err_before;
        err_before   = errors;
        test_idx     = t;
        @(negedge clk);
        rst_n        = 1'b0;
        stop_fetch_i = 1'b0;
        go          <= 1'b0;
        stall       <= mode[0];
        slow        <= mode[1];
        exp_cnt     <= cnt;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (mode[1]) begin                          // Decoy target left pending
            redirect(pc + 32'h80);
            repeat (2) @(negedge clk);
        end
        redirect(pc);
        go <= 1'b1;
        while (consumed < cnt) @(negedge clk);
        if (mode[2]) begin                          // Fault must halt the stream
            repeat (20) begin
                @(negedge clk);
                if (idu_o.valid) begin
                    errors++;
                    $display("Test %0d: a valid instruction followed the fault", t);
                end
            end
        end
        stop_fetch_i = 1'b1;
        repeat (10) begin
            @(negedge clk);
            checks++;
            if (imem_req_o.req) begin
                errors++;
                $display("Test %0d: memory request raised after stop", t);
            end
            if (idu_o.valid) begin
                errors++;
                $display("Test %0d: valid instruction shown after stop", t);
            end
        end
        $display("Test %0d at pc %h mode %0d: %0d instructions, %0d errors",
                 t, pc, mode, cnt, errors - err_before);
    endtask

    initial begin
        int n_tests;
        int total;
        rst_n        = 1'b0;
        pc_new_req_i = 1'b0;
        pc_new_i     = '0;
        stop_fetch_i = 1'b0;
        imem_ack_i   = 1'b0;
        idu_rdy_i    = 1'b0;
        imem_resp_i  = '0;
        errors       = 0;
        checks       = 0;
        total        = 0;
        $readmemh("dv/ifu_testdata.txt", tdata);
        err_mask = {tdata[MASK_AT + 1], tdata[MASK_AT]};
        n_tests  = tdata[NTEST_AT];
        for (int t = 0; t < n_tests; t++) total += tdata[REC_AT + 3 * t + 2];
        watchdog_cycles = total * CYC_PER_INSTR + n_tests * CYC_PER_TEST;
        loaded   = 1'b1;
        exp_base = EXP_AT;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t, tdata[REC_AT + 3 * t], tdata[REC_AT + 3 * t + 1],
                     tdata[REC_AT + 3 * t + 2]);
            exp_base += 2 * tdata[REC_AT + 3 * t + 2];
        end
        errors += i_ifu_top.i_imem_ctrl.i_ifu_sva.fail_cnt;  // Assertion failures
        $display("Tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* dv/ifu_testdata.txt */
// 00-3F memory image, 40-41 fault mask, 42 test count, 43 records (pc mode count)
// 60 expected pairs (instr, flags: bit1 imem_err, bit0 err_rvi_hi); mode bit0 stall,
// bit1 decoy redirect, bit2 silence after fault
@00
40850505 00a00513 05934505 808200b0 06130001 069300c0 050500d0 00e00713
00850081 00950091 00a500a1 00b500b1 00c500c1 00d500d1 00e500e1 00f500f1
07934781 000500f0 01250121 01350131 01450141 01550151 01650161 01750171
01850181 01950191 01a501a1 01b501b1 01c501c1 01d501d1 01e501e1 01f501f1
02050201 02150211 02250221 02350231 02450241 02550251 02650261 02750271
02850281 02950291 02a502a1 02b502b1 02c502c1 02d502d1 02e502e1 02f502f1
03050301 03150311 03250321 03350331 03450341 03550351 03650361 03750371
03850381 03950391 03a503a1 03b503b1 03c503c1 03d503d1 03e503e1 03f503f1
@40
00020000 00000000
00000006
00000000 00000000 0000000b
00000000 00000001 0000000b
0000000a 00000000 00000007
00000004 00000002 00000009
00000040 00000004 00000003
00000004 00000003 00000009
@60
// Aligned start, then the same with stalls
00000505 0 00004085 0 00a00513 0 00004505 0
00b00593 0 00008082 0 00000001 0 00c00613 0
00d00693 0 00000505 0 00e00713 0
00000505 0 00004085 0 00a00513 0 00004505 0
00b00593 0 00008082 0 00000001 0 00c00613 0
00d00693 0 00000505 0 00e00713 0
// Start on the upper parcel
00b00593 0 00008082 0 00000001 0 00c00613 0
00d00693 0 00000505 0 00e00713 0
// Redirect over pending decoy words
00a00513 0 00004505 0 00b00593 0 00008082 0
00000001 0 00c00613 0 00d00693 0 00000505 0
00e00713 0
// Fault on the upper half of a straddling RVI
00004781 0 00f00793 3 00000005 2
// Redirect over decoy words with stalls
00a00513 0 00004505 0 00b00593 0 00008082 0
00000001 0 00c00613 0 00d00693 0 00000505 0
00e00713 0

/* logic/ifu_imem_ctrl.sv */
`timescale 1ns/1ns

module ifu_imem_ctrl #(
    parameter int TXN_CNT_W = 3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pc_new_req_i,   // Redirect strobe
    input  logic [ifu_pkg::XLEN-1:0] pc_new_i,
    input  logic                     stop_fetch_i,   // Level
    input  logic                     imem_ack_i,
    input  ifu_pkg::imem_resp_t      imem_resp_i,
    input  logic                     q_has_room_i,
    output ifu_pkg::imem_req_t       imem_req_o,
    output logic                     resp_vd_o,      // Response kept
    output logic                     resp_err_o,     // Kept and faulty
    output logic                     flush_o,
    output logic [TXN_CNT_W-1:0]     vd_pnd_cnt_o    // Pending, not to be dropped
);
    import ifu_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_FETCH
    } state_e;

    state_e               state;
    state_e               state_nxt;
    logic                 resp_ok;
    logic                 resp_er;
    logic                 resp_rcvd;
    logic                 discard;
    logic                 hs;
    logic                 fetch_req;
    logic                 stop_req;
    logic [XLEN-1:2]      addr_q;
    logic [XLEN-1:2]      addr_nxt;
    logic [TXN_CNT_W-1:0] pnd_cnt;
    logic [TXN_CNT_W-1:0] pnd_nxt;
    logic                 pnd_full;
    logic [TXN_CNT_W-1:0] dsc_cnt;
    logic [TXN_CNT_W-1:0] dsc_nxt;
    logic                 dsc_upd;

    // --------------------------------------------------
    // Response qualification
    // --------------------------------------------------

    assign resp_ok    = (imem_resp_i.resp == RESP_OK);
    assign resp_er    = (imem_resp_i.resp == RESP_ERR);
    assign resp_rcvd  = resp_ok | resp_er;
    assign discard    = |dsc_cnt;                    // Stale responses still due

    assign resp_vd_o  = resp_rcvd & ~discard;
    assign resp_err_o = resp_er & ~discard;
    assign flush_o    = pc_new_req_i | stop_fetch_i;

    assign hs = imem_req_o.req & imem_ack_i;         // Request accepted

    // --------------------------------------------------
    // Fetch FSM
    // --------------------------------------------------

    assign fetch_req = pc_new_req_i & ~stop_fetch_i;
    // A real fault halts fetch unless a redirect lands on top of it
    assign stop_req  = stop_fetch_i | (resp_err_o & ~pc_new_req_i);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (fetch_req) state_nxt = ST_FETCH;
            ST_FETCH: if (stop_req)  state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= ST_IDLE;
        else        state <= state_nxt;
    end

    // --------------------------------------------------
    // Word address
    // --------------------------------------------------

    // Carry out of bits 5:2 only at the block end
    always_comb begin
        if (pc_new_req_i) begin
            addr_nxt = pc_new_i[XLEN-1:2] + (XLEN-2)'(hs);  // Target already issued
        end else if (&addr_q[5:2]) begin
            addr_nxt = addr_q + (XLEN-2)'(hs);
        end else begin
            addr_nxt = {addr_q[XLEN-1:6], addr_q[5:2] + 4'(hs)};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)                   addr_q <= '0;
        else if (hs | pc_new_req_i)   addr_q <= addr_nxt;
    end

    // --------------------------------------------------
    // Pending and discard counters
    // --------------------------------------------------

    assign pnd_nxt  = pnd_cnt + TXN_CNT_W'(hs) - TXN_CNT_W'(resp_rcvd);
    assign pnd_full = &pnd_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)                 pnd_cnt <= '0;
        else if (hs ^ resp_rcvd)    pnd_cnt <= pnd_nxt;
    end

    // Redirect drops all older requests, a fault drops all younger ones
    assign dsc_upd = pc_new_req_i | resp_er | (resp_ok & discard);
    assign dsc_nxt = pc_new_req_i ? pnd_nxt - TXN_CNT_W'(hs)    // Keep the new one
                   : resp_err_o   ? pnd_nxt
                                  : dsc_cnt - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)       dsc_cnt <= '0;
        else if (dsc_upd) dsc_cnt <= dsc_nxt;
    end

    assign vd_pnd_cnt_o = pnd_cnt - dsc_cnt;

    // --------------------------------------------------
    // Request
    // --------------------------------------------------

    assign imem_req_o.req  = (pc_new_req_i & ~pnd_full & ~stop_fetch_i)
                           | ((state == ST_FETCH) & ~pnd_full & q_has_room_i);
    assign imem_req_o.addr = pc_new_req_i ? pc_new_i[XLEN-1:2] : addr_q;

endmodule

/* logic/ifu_instr_queue.sv */
`timescale 1ns/1ns

module ifu_instr_queue #(
    parameter int QUEUE_WORDS = 2,      // Power of two
    parameter int TXN_CNT_W   = 3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [ifu_pkg::XLEN-1:0] rdata_i,
    input  logic                     resp_vd_i,
    input  logic                     resp_err_i,
    input  logic                     flush_i,
    input  ifu_pkg::wr_size_e        wr_size_i,
    input  logic [TXN_CNT_W-1:0]     vd_pnd_cnt_i,
    input  logic                     idu_rdy_i,
    output logic                     q_has_room_o,
    output ifu_pkg::idu_out_t        idu_o
);
    import ifu_pkg::*;

    localparam int HALVES = QUEUE_WORDS * 2;
    localparam int ADR_W  = $clog2(HALVES);
    localparam int PTR_W  = ADR_W + 1;                          // Extra wrap bit
    localparam int CMP_W  = (PTR_W > TXN_CNT_W) ? PTR_W : TXN_CNT_W;

    logic [HALF_W-1:0] q_data [HALVES];
    logic              q_err  [HALVES];

    logic [PTR_W-1:0]  wptr;
    logic [PTR_W-1:0]  rptr;
    logic [PTR_W-1:0]  rptr_nxt;
    logic              wr_en;
    logic              rd_vd;
    logic              rd_hword;
    logic [ADR_W-1:0]  head_idx;
    logic [ADR_W-1:0]  next_idx;
    logic [HALF_W-1:0] head;
    logic [HALF_W-1:0] next;
    logic              err_head;
    logic              err_next;
    logic              head_is_rvi;
    logic              is_empty;
    logic              one_half;
    logic [PTR_W-1:0]  ocpd_h;
    logic [PTR_W-1:0]  free_h_nxt;
    logic [PTR_W-1:0]  free_w_nxt;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    assign wr_en = resp_vd_i & ~flush_i;       // Redirect beats a late word

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr_size_i)
                WR_HI: begin
                    q_data[wptr[ADR_W-1:0]] <= rdata_i[XLEN-1:HALF_W];
                    q_err[wptr[ADR_W-1:0]]  <= resp_err_i;
                end
                WR_FULL: begin
                    q_data[wptr[ADR_W-1:0]]            <= rdata_i[HALF_W-1:0];
                    q_err[wptr[ADR_W-1:0]]             <= resp_err_i;
                    q_data[ADR_W'(wptr + PTR_W'(1))]   <= rdata_i[XLEN-1:HALF_W];
                    q_err[ADR_W'(wptr + PTR_W'(1))]    <= resp_err_i;
                end
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // Pointers
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr <= '0;
        end else if (flush_i) begin
            wptr <= '0;
        end else if (wr_en && wr_size_i != WR_NONE) begin
            wptr <= wptr + ((wr_size_i == WR_FULL) ? PTR_W'(2) : PTR_W'(1));
        end
    end

    assign rd_vd    = idu_o.valid & idu_rdy_i;
    assign rd_hword = ~head_is_rvi | err_head;  // Faulty parcel goes alone
    assign rptr_nxt = flush_i ? '0
                    : rd_vd   ? rptr + (rd_hword ? PTR_W'(1) : PTR_W'(2))
                              : rptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) rptr <= '0;
        else        rptr <= rptr_nxt;
    end

    // --------------------------------------------------
    // Status
    // --------------------------------------------------

    assign ocpd_h     = wptr - rptr;
    assign is_empty   = (rptr == wptr);
    assign one_half   = (ocpd_h == PTR_W'(1));
    assign free_h_nxt = PTR_W'(HALVES) - (wptr - rptr_nxt);     // After this read
    assign free_w_nxt = free_h_nxt >> 1;

    // Every kept in-flight word already owns a slot
    assign q_has_room_o = CMP_W'(free_w_nxt) > CMP_W'(vd_pnd_cnt_i);

    // --------------------------------------------------
    // Decode-stage output
    // --------------------------------------------------

    assign head_idx    = rptr[ADR_W-1:0];
    assign next_idx    = ADR_W'(rptr + PTR_W'(1));
    assign head        = q_data[head_idx];
    assign next        = q_data[next_idx];
    assign err_head    = q_err[head_idx];
    assign err_next    = q_err[next_idx];
    assign head_is_rvi = &head[1:0];

    always_comb begin
        idu_o.valid      = 1'b0;
        idu_o.imem_err   = 1'b0;
        idu_o.err_rvi_hi = 1'b0;
        idu_o.instr      = rd_hword ? XLEN'(head) : {next, head};
        if (!is_empty) begin
            idu_o.err_rvi_hi = ~err_head & head_is_rvi & err_next;
            if (one_half) begin
                idu_o.valid    = rd_hword;              // RVI waits for its upper half
                idu_o.imem_err = err_head;
            end else begin
                idu_o.valid    = 1'b1;
                idu_o.imem_err = err_head | (head_is_rvi & err_next);
            end
        end
    end

endmodule

/* logic/ifu_parcel_align.sv */
`timescale 1ns/1ns

module ifu_parcel_align (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pc_new_req_i,
    input  logic                     pc_new_bit1_i,   // Target on upper parcel
    input  logic [ifu_pkg::XLEN-1:0] rdata_i,
    input  logic                     resp_vd_i,
    input  logic                     resp_err_i,
    output ifu_pkg::wr_size_e        wr_size_o
);
    import ifu_pkg::*;

    logic        unalign_q;     // Next word starts mid-word
    logic        straddle_q;    // Last word ended on an RVI low half
    logic        straddle_nxt;
    logic        hi_rvi;
    logic        lo_rvi;
    instr_kind_e kind;

    assign hi_rvi = &rdata_i[17:16];
    assign lo_rvi = &rdata_i[1:0];

    // Classify a kept OK word
    always_comb begin
        kind = NONE;
        if (resp_vd_i & ~resp_err_i) begin
            if (unalign_q) begin
                kind = hi_rvi ? RVI_LO_NV : RVC_NV;
            end else if (straddle_q) begin
                kind = hi_rvi ? RVI_LO_RVI_HI : RVC_RVI_HI;  // Low half ends prior RVI
            end else begin
                case ({hi_rvi, lo_rvi})
                    2'b00:   kind = RVC_RVC;
                    2'b10:   kind = RVI_LO_RVC;
                    default: kind = RVI_HI_RVI_LO;
                endcase
            end
        end
    end

    assign straddle_nxt = (kind == RVI_LO_NV) | (kind == RVI_LO_RVI_HI) | (kind == RVI_LO_RVC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unalign_q  <= 1'b0;
            straddle_q <= 1'b0;
        end else if (pc_new_req_i) begin
            unalign_q  <= pc_new_bit1_i;
            straddle_q <= 1'b0;
        end else if (resp_vd_i) begin
            unalign_q  <= 1'b0;         // Only the first word is cut
            straddle_q <= straddle_nxt;
        end
    end

    // Queue write size
    always_comb begin
        wr_size_o = WR_NONE;
        if (resp_vd_i) begin
            if (resp_err_i) begin
                wr_size_o = WR_FULL;    // Both halves flagged
            end else begin
                case (kind)
                    NONE:              wr_size_o = WR_NONE;
                    RVC_NV, RVI_LO_NV: wr_size_o = WR_HI;
                    default:           wr_size_o = WR_FULL;
                endcase
            end
        end
    end

endmodule

/* logic/ifu_pkg.sv */
package ifu_pkg;

    // Data path widths
    parameter int XLEN   = 32;
    parameter int HALF_W = 16;                  // One 16-bit parcel

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------

    typedef enum logic [1:0] {
        RESP_NONE,                              // Nothing this cycle
        RESP_OK,
        RESP_ERR                                // Access fault
    } mem_resp_e;

    typedef enum logic [1:0] {
        WR_NONE,
        WR_HI,                                  // Upper parcel only
        WR_FULL                                 // Both parcels
    } wr_size_e;

    // Named <upper parcel>_<lower parcel> of the fetched word
    typedef enum logic [2:0] {
        NONE,
        RVI_HI_RVI_LO,                          // Aligned 32-bit instr
        RVC_RVC,
        RVI_LO_RVC,
        RVC_RVI_HI,
        RVI_LO_RVI_HI,
        RVC_NV,                                 // Lower parcel skipped
        RVI_LO_NV
    } instr_kind_e;

    // --------------------------------------------------
    // Bundles
    // --------------------------------------------------

    typedef struct packed {
        logic            req;
        logic [XLEN-1:2] addr;                  // Word address
    } imem_req_t;

    typedef struct packed {
        mem_resp_e       resp;
        logic [XLEN-1:0] rdata;
    } imem_resp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] instr;                 // RVC sits in bits 15:0
        logic            imem_err;
        logic            err_rvi_hi;            // Fault on upper half only
    } idu_out_t;

endpackage

/* logic/ifu_top.sv */
`timescale 1ns/1ns

module ifu_top #(
    parameter int QUEUE_WORDS = 2,      // Queue depth in words
    parameter int TXN_CNT_W   = 3       // Up to 2^W-1 requests in flight
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pc_new_req_i,
    input  logic [ifu_pkg::XLEN-1:0] pc_new_i,
    input  logic                     stop_fetch_i,
    output ifu_pkg::imem_req_t       imem_req_o,
    input  logic                     imem_ack_i,
    input  ifu_pkg::imem_resp_t      imem_resp_i,
    output ifu_pkg::idu_out_t        idu_o,
    input  logic                     idu_rdy_i
);
    import ifu_pkg::*;

    logic                 resp_vd;
    logic                 resp_err;
    logic                 flush;
    logic                 q_has_room;
    logic [TXN_CNT_W-1:0] vd_pnd_cnt;
    wr_size_e             wr_size;

    // Memory side
    ifu_imem_ctrl #(
        .TXN_CNT_W    (TXN_CNT_W)
    ) i_imem_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_new_req_i (pc_new_req_i),
        .pc_new_i     (pc_new_i),
        .stop_fetch_i (stop_fetch_i),
        .imem_ack_i   (imem_ack_i),
        .imem_resp_i  (imem_resp_i),
        .q_has_room_i (q_has_room),
        .imem_req_o   (imem_req_o),
        .resp_vd_o    (resp_vd),
        .resp_err_o   (resp_err),
        .flush_o      (flush),
        .vd_pnd_cnt_o (vd_pnd_cnt)
    );

    // Word to parcel split
    ifu_parcel_align i_parcel_align (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_new_req_i  (pc_new_req_i),
        .pc_new_bit1_i (pc_new_i[1]),
        .rdata_i       (imem_resp_i.rdata),
        .resp_vd_i     (resp_vd),
        .resp_err_i    (resp_err),
        .wr_size_o     (wr_size)
    );

    // Parcel buffer and decode-stage handshake
    ifu_instr_queue #(
        .QUEUE_WORDS  (QUEUE_WORDS),
        .TXN_CNT_W    (TXN_CNT_W)
    ) i_instr_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdata_i      (imem_resp_i.rdata),
        .resp_vd_i    (resp_vd),
        .resp_err_i   (resp_err),
        .flush_i      (flush),
        .wr_size_i    (wr_size),
        .vd_pnd_cnt_i (vd_pnd_cnt),
        .idu_rdy_i    (idu_rdy_i),
        .q_has_room_o (q_has_room),
        .idu_o        (idu_o)
    );

endmodule
